// ==== logic/flight_pkg.sv ====
// flight_pkg: widths, stick and motor ranges, tick divider and PWM timing of the flight core
`default_nettype none

package flight_pkg;

	// Stick and motor value ranges
	localparam int STICK_W   = 8;
	localparam int STICK_MAX = 250;
	localparam int STICK_MID = 125;
	localparam int MOTOR_W   = 8;
	// Motors idle below this throttle
	localparam int ARM_MIN   = 10;

	// Microsecond tick, scaled down for simulation
	localparam int TICK_DIV = 4;
	localparam int TICK_W   = $clog2(TICK_DIV);

	// Pulse timing in ticks
	localparam int PULSE_MIN_US = 1000;
	localparam int PULSE_MAX_US = 2000;
	localparam int PWM_FRAME_US = 2500;
	localparam int US_W         = 12;
	// 1000 us span over 250 steps
	localparam int STEP_SHIFT   = 2;

	// Control path widths
	localparam int IMU_W    = 8;
	localparam int KP_W     = 8;
	localparam int KP_SHIFT = 4;
	localparam int ERR_W    = 10;
	localparam int CORR_W   = 16;
	localparam int MIX_W    = 18;

endpackage

`default_nettype wire

// ==== logic/regs_pkg.sv ====
// regs_pkg: APB register map and field positions of the flight core
`default_nettype none

package regs_pkg;

	localparam int ADDR_W = 5;
	localparam int DATA_W = 32;

	// Register offsets
	localparam logic [ADDR_W-1:0] REG_CTRL  = 'h0;
	localparam logic [ADDR_W-1:0] REG_IMU   = 'h4;
	localparam logic [ADDR_W-1:0] REG_STICK = 'h8;
	localparam logic [ADDR_W-1:0] REG_MOTOR = 'hC;

	// Field positions
	localparam int KP_LSB    = 0;
	localparam int ROLL_LSB  = 0;
	localparam int PITCH_LSB = 8;
	localparam int YAW_LSB   = 16;

endpackage

`default_nettype wire

// ==== logic/flight_if.sv ====
// flight_if: stick and motor bundles passed between the flight core blocks
`timescale 1ns/1ps
`default_nettype none

interface stick_if;
	// Held values, always valid
	logic [flight_pkg::STICK_W-1:0] throttle;
	logic [flight_pkg::STICK_W-1:0] roll;
	logic [flight_pkg::STICK_W-1:0] pitch;
	logic [flight_pkg::STICK_W-1:0] yaw;

	modport src (output throttle, roll, pitch, yaw);
	modport dst (input throttle, roll, pitch, yaw);
endinterface

interface motor_if;
	logic [flight_pkg::MOTOR_W-1:0] motor_1;
	logic [flight_pkg::MOTOR_W-1:0] motor_2;
	logic [flight_pkg::MOTOR_W-1:0] motor_3;
	logic [flight_pkg::MOTOR_W-1:0] motor_4;
	// One cycle strobe with each new set of rates
	logic update;

	modport src (output motor_1, motor_2, motor_3, motor_4, update);
	modport dst (input motor_1, motor_2, motor_3, motor_4, update);
endinterface

`default_nettype wire

// ==== logic/rc_capture.sv ====
// rc_capture: microsecond tick and four-channel receiver pulse-width to stick conversion
`timescale 1ns/1ps
`default_nettype none

module rc_capture (
	input  wire  sys_clk,
	input  wire  resetn,
	input  wire  throttle_pwm,
	input  wire  roll_pwm,
	input  wire  pitch_pwm,
	input  wire  yaw_pwm,
	output logic tick,
	stick_if.src sticks
);

	logic [flight_pkg::TICK_W-1:0]  div_cnt;
	logic [3:0]                     pwm_in;
	logic [flight_pkg::STICK_W-1:0] stick_val [4];

	// Count in ticks to stick value, clamped to 0..250
	function automatic logic [flight_pkg::STICK_W-1:0] to_stick(
		input logic [flight_pkg::US_W-1:0] us
	);
		if (us <= flight_pkg::US_W'(flight_pkg::PULSE_MIN_US))
			return '0;
		else if (us >= flight_pkg::US_W'(flight_pkg::PULSE_MAX_US))
			return flight_pkg::STICK_W'(flight_pkg::STICK_MAX);
		else
			return flight_pkg::STICK_W'((us - flight_pkg::US_W'(flight_pkg::PULSE_MIN_US))
				>> flight_pkg::STEP_SHIFT);
	endfunction

	// Tick on the last cycle of each divider period
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else begin
			tick <= (div_cnt == flight_pkg::TICK_W'(flight_pkg::TICK_DIV - 1));
			if (div_cnt == flight_pkg::TICK_W'(flight_pkg::TICK_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	assign pwm_in = {yaw_pwm, pitch_pwm, roll_pwm, throttle_pwm};

	for (genvar ch = 0; ch < 4; ch++) begin : g_ch
		logic [1:0]                     sync_q;
		logic                           high_q;
		logic [flight_pkg::US_W-1:0]    cnt_q;
		logic [flight_pkg::STICK_W-1:0] val_q;

		always_ff @(posedge sys_clk) begin
			if (!resetn) begin
				sync_q <= '0;
				high_q <= 1'b0;
				cnt_q  <= '0;
				val_q  <= '0;
			end else begin
				sync_q <= {sync_q[0], pwm_in[ch]};
				if (tick) begin
					if (sync_q[1]) begin
						high_q <= 1'b1;
						// Saturate on stuck-high inputs
						if (cnt_q != '1)
							cnt_q <= cnt_q + 1'b1;
					end else if (high_q) begin
						// First tick after the falling edge
						high_q <= 1'b0;
						cnt_q  <= '0;
						val_q  <= to_stick(cnt_q);
					end
				end
			end
		end

		assign stick_val[ch] = val_q;
	end

	assign sticks.throttle = stick_val[0];
	assign sticks.roll     = stick_val[1];
	assign sticks.pitch    = stick_val[2];
	assign sticks.yaw      = stick_val[3];

endmodule

`default_nettype wire

// ==== logic/apb_regs.sv ====
// apb_regs: APB slave for gain and IMU sample, with stick and motor readback
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
	input  wire                                sys_clk,
	input  wire                                resetn,
	input  wire  [regs_pkg::ADDR_W-1:0]        paddr,
	input  wire                                psel,
	input  wire                                penable,
	input  wire                                pwrite,
	input  wire  [regs_pkg::DATA_W-1:0]        pwdata,
	output logic [regs_pkg::DATA_W-1:0]        prdata,
	output logic                               pready,
	output logic                               pslverr,
	stick_if.dst                               sticks,
	motor_if.dst                               motors,
	output logic signed [flight_pkg::IMU_W-1:0] roll_angle,
	output logic signed [flight_pkg::IMU_W-1:0] pitch_angle,
	output logic signed [flight_pkg::IMU_W-1:0] yaw_rate,
	output logic [flight_pkg::KP_W-1:0]        kp,
	output logic                               sample
);

	logic access;
	logic wr;
	logic mapped;
	logic read_only;
	logic imu_wr;
	logic signed [flight_pkg::IMU_W-1:0] roll_q;
	logic signed [flight_pkg::IMU_W-1:0] pitch_q;
	logic signed [flight_pkg::IMU_W-1:0] yaw_q;

	// Zero wait states, access phase only
	assign access = psel & penable;
	assign wr     = access & pwrite;
	assign pready = 1'b1;

	assign mapped    = paddr inside {regs_pkg::REG_CTRL, regs_pkg::REG_IMU,
		regs_pkg::REG_STICK, regs_pkg::REG_MOTOR};
	assign read_only = paddr inside {regs_pkg::REG_STICK, regs_pkg::REG_MOTOR};
	assign pslverr   = access & (!mapped | (pwrite & read_only));

	// IMU write kicks off one control update
	assign imu_wr = wr & (paddr == regs_pkg::REG_IMU);
	assign sample = imu_wr;

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			kp      <= '0;
			roll_q  <= '0;
			pitch_q <= '0;
			yaw_q   <= '0;
		end else begin
			if (wr && paddr == regs_pkg::REG_CTRL)
				kp <= pwdata[regs_pkg::KP_LSB +: flight_pkg::KP_W];
			if (imu_wr) begin
				roll_q  <= pwdata[regs_pkg::ROLL_LSB +: flight_pkg::IMU_W];
				pitch_q <= pwdata[regs_pkg::PITCH_LSB +: flight_pkg::IMU_W];
				yaw_q   <= pwdata[regs_pkg::YAW_LSB +: flight_pkg::IMU_W];
			end
		end
	end

	// Mixer samples in the write cycle, so pass the incoming word straight on
	assign roll_angle  = imu_wr ? pwdata[regs_pkg::ROLL_LSB +: flight_pkg::IMU_W] : roll_q;
	assign pitch_angle = imu_wr ? pwdata[regs_pkg::PITCH_LSB +: flight_pkg::IMU_W] : pitch_q;
	assign yaw_rate    = imu_wr ? pwdata[regs_pkg::YAW_LSB +: flight_pkg::IMU_W] : yaw_q;

	// Read mux, valid in the access cycle
	always_comb begin
		prdata = '0;
		case (paddr)
			regs_pkg::REG_CTRL: begin
				prdata[regs_pkg::KP_LSB +: flight_pkg::KP_W] = kp;
			end
			regs_pkg::REG_IMU: begin
				prdata[regs_pkg::ROLL_LSB +: flight_pkg::IMU_W]  = roll_q;
				prdata[regs_pkg::PITCH_LSB +: flight_pkg::IMU_W] = pitch_q;
				prdata[regs_pkg::YAW_LSB +: flight_pkg::IMU_W]   = yaw_q;
			end
			regs_pkg::REG_STICK: begin
				prdata = {sticks.yaw, sticks.pitch, sticks.roll, sticks.throttle};
			end
			regs_pkg::REG_MOTOR: begin
				prdata = {motors.motor_4, motors.motor_3, motors.motor_2, motors.motor_1};
			end
			default: begin
				prdata = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/control_mixer.sv ====
// control_mixer: proportional axis correction and quad-X motor mix in two pipeline stages
`timescale 1ns/1ps
`default_nettype none

module control_mixer (
	input  wire                                sys_clk,
	input  wire                                resetn,
	stick_if.dst                               sticks,
	input  wire signed [flight_pkg::IMU_W-1:0] roll_angle,
	input  wire signed [flight_pkg::IMU_W-1:0] pitch_angle,
	input  wire signed [flight_pkg::IMU_W-1:0] yaw_rate,
	input  wire        [flight_pkg::KP_W-1:0]  kp,
	input  wire                                sample,
	motor_if.src                               motors
);

	logic signed [flight_pkg::ERR_W-1:0]  roll_err;
	logic signed [flight_pkg::ERR_W-1:0]  pitch_err;
	logic signed [flight_pkg::ERR_W-1:0]  yaw_err;
	logic                                 s1_valid;
	logic [flight_pkg::STICK_W-1:0]       thr_q;
	logic signed [flight_pkg::CORR_W-1:0] roll_c;
	logic signed [flight_pkg::CORR_W-1:0] pitch_c;
	logic signed [flight_pkg::CORR_W-1:0] yaw_c;
	logic signed [flight_pkg::MIX_W-1:0]  thr_x;
	logic signed [flight_pkg::MIX_W-1:0]  roll_x;
	logic signed [flight_pkg::MIX_W-1:0]  pitch_x;
	logic signed [flight_pkg::MIX_W-1:0]  yaw_x;
	logic signed [flight_pkg::MIX_W-1:0]  mix [4];
	logic                                 disarm;

	// Stick offset from centre minus measured value
	function automatic logic signed [flight_pkg::ERR_W-1:0] axis_err(
		input logic [flight_pkg::STICK_W-1:0] stick,
		input logic signed [flight_pkg::IMU_W-1:0] meas
	);
		logic signed [flight_pkg::ERR_W-1:0] s_ext;
		s_ext = $signed({{(flight_pkg::ERR_W - flight_pkg::STICK_W){1'b0}}, stick});
		return s_ext - flight_pkg::ERR_W'(flight_pkg::STICK_MID) - flight_pkg::ERR_W'(meas);
	endfunction

	// Gain multiply, arithmetic shift keeps the sign
	function automatic logic signed [flight_pkg::CORR_W-1:0] scale(
		input logic signed [flight_pkg::ERR_W-1:0] err,
		input logic [flight_pkg::KP_W-1:0] gain
	);
		logic signed [flight_pkg::ERR_W+flight_pkg::KP_W:0] prod;
		prod = err * $signed({1'b0, gain});
		return flight_pkg::CORR_W'(prod >>> flight_pkg::KP_SHIFT);
	endfunction

	function automatic logic [flight_pkg::MOTOR_W-1:0] clamp(
		input logic signed [flight_pkg::MIX_W-1:0] v
	);
		if (v < 0)
			return '0;
		else if (v > flight_pkg::STICK_MAX)
			return flight_pkg::MOTOR_W'(flight_pkg::STICK_MAX);
		else
			return v[flight_pkg::MOTOR_W-1:0];
	endfunction

	assign roll_err  = axis_err(sticks.roll, roll_angle);
	assign pitch_err = axis_err(sticks.pitch, pitch_angle);
	assign yaw_err   = axis_err(sticks.yaw, yaw_rate);

	// Stage one, corrections and throttle
	always_ff @(posedge sys_clk) begin
		if (!resetn)
			s1_valid <= 1'b0;
		else
			s1_valid <= sample;
	end

	always_ff @(posedge sys_clk) begin
		if (sample) begin
			thr_q   <= sticks.throttle;
			roll_c  <= scale(roll_err, kp);
			pitch_c <= scale(pitch_err, kp);
			yaw_c   <= scale(yaw_err, kp);
		end
	end

	// Stage two, quad-X mix
	assign thr_x   = $signed({{(flight_pkg::MIX_W - flight_pkg::STICK_W){1'b0}}, thr_q});
	assign roll_x  = flight_pkg::MIX_W'(roll_c);
	assign pitch_x = flight_pkg::MIX_W'(pitch_c);
	assign yaw_x   = flight_pkg::MIX_W'(yaw_c);

	assign mix[0] = thr_x + pitch_x + roll_x - yaw_x;
	assign mix[1] = thr_x + pitch_x - roll_x + yaw_x;
	assign mix[2] = thr_x - pitch_x - roll_x - yaw_x;
	assign mix[3] = thr_x - pitch_x + roll_x + yaw_x;

	assign disarm = (thr_q < flight_pkg::STICK_W'(flight_pkg::ARM_MIN));

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			motors.motor_1 <= '0;
			motors.motor_2 <= '0;
			motors.motor_3 <= '0;
			motors.motor_4 <= '0;
			motors.update  <= 1'b0;
		end else begin
			motors.update <= s1_valid;
			if (s1_valid) begin
				// Low throttle holds every motor off
				motors.motor_1 <= disarm ? '0 : clamp(mix[0]);
				motors.motor_2 <= disarm ? '0 : clamp(mix[1]);
				motors.motor_3 <= disarm ? '0 : clamp(mix[2]);
				motors.motor_4 <= disarm ? '0 : clamp(mix[3]);
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/motor_pwm.sv ====
// motor_pwm: four ESC pulse outputs, 1000 to 2000 ticks wide in a 2500 tick frame
`timescale 1ns/1ps
`default_nettype none

module motor_pwm (
	input  wire  sys_clk,
	input  wire  resetn,
	input  wire  tick,
	motor_if.dst motors,
	output logic motor_1_pwm,
	output logic motor_2_pwm,
	output logic motor_3_pwm,
	output logic motor_4_pwm
);

	logic [flight_pkg::US_W-1:0]    frame_cnt;
	logic                           frame_end;
	logic                           armed;
	logic                           live;
	logic [flight_pkg::MOTOR_W-1:0] rate [4];
	logic [3:0]                     pwm_out;

	assign rate[0] = motors.motor_1;
	assign rate[1] = motors.motor_2;
	assign rate[2] = motors.motor_3;
	assign rate[3] = motors.motor_4;

	assign frame_end = tick && (frame_cnt == flight_pkg::US_W'(flight_pkg::PWM_FRAME_US - 1));

	// ESCs stay silent until the mixer has delivered rates
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			frame_cnt <= '0;
			armed     <= 1'b0;
			live      <= 1'b0;
		end else begin
			if (motors.update)
				armed <= 1'b1;
			if (tick)
				frame_cnt <= frame_end ? '0 : frame_cnt + 1'b1;
			if (frame_end)
				live <= armed | motors.update;
		end
	end

	for (genvar ch = 0; ch < 4; ch++) begin : g_ch
		logic [flight_pkg::US_W-1:0] width_q;
		logic                        pwm_q;

		// Width taken once per frame
		always_ff @(posedge sys_clk) begin
			if (frame_end)
				width_q <= flight_pkg::US_W'(flight_pkg::PULSE_MIN_US)
					+ (flight_pkg::US_W'(rate[ch]) << flight_pkg::STEP_SHIFT);
		end

		always_ff @(posedge sys_clk) begin
			if (!resetn)
				pwm_q <= 1'b0;
			else
				pwm_q <= live && (frame_cnt < width_q);
		end

		assign pwm_out[ch] = pwm_q;
	end

	assign motor_1_pwm = pwm_out[0];
	assign motor_2_pwm = pwm_out[1];
	assign motor_3_pwm = pwm_out[2];
	assign motor_4_pwm = pwm_out[3];

endmodule

`default_nettype wire

// ==== logic/flight_core.sv ====
// flight_core: flight control core with receiver capture, APB registers, mixer and ESC PWM
`timescale 1ns/1ps
`default_nettype none

module flight_core (
	input  wire                         sys_clk,
	input  wire                         resetn,
	// APB slave
	input  wire  [regs_pkg::ADDR_W-1:0] paddr,
	input  wire                         psel,
	input  wire                         penable,
	input  wire                         pwrite,
	input  wire  [regs_pkg::DATA_W-1:0] pwdata,
	output logic [regs_pkg::DATA_W-1:0] prdata,
	output logic                        pready,
	output logic                        pslverr,
	// Receiver pulses
	input  wire                         throttle_pwm,
	input  wire                         roll_pwm,
	input  wire                         pitch_pwm,
	input  wire                         yaw_pwm,
	// ESC pulses
	output logic                        motor_1_pwm,
	output logic                        motor_2_pwm,
	output logic                        motor_3_pwm,
	output logic                        motor_4_pwm
);

	logic                               tick;
	logic signed [flight_pkg::IMU_W-1:0] roll_angle;
	logic signed [flight_pkg::IMU_W-1:0] pitch_angle;
	logic signed [flight_pkg::IMU_W-1:0] yaw_rate;
	logic [flight_pkg::KP_W-1:0]        kp;
	logic                               sample;

	stick_if sticks ();
	motor_if motors ();

	rc_capture rc_capture0 (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.throttle_pwm(throttle_pwm),
		.roll_pwm(roll_pwm),
		.pitch_pwm(pitch_pwm),
		.yaw_pwm(yaw_pwm),
		.tick(tick),
		.sticks(sticks.src)
	);

	apb_regs apb_regs0 (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.sticks(sticks.dst),
		.motors(motors.dst),
		.roll_angle(roll_angle),
		.pitch_angle(pitch_angle),
		.yaw_rate(yaw_rate),
		.kp(kp),
		.sample(sample)
	);

	// Sample strobe starts the two stage update
	control_mixer control_mixer0 (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.sticks(sticks.dst),
		.roll_angle(roll_angle),
		.pitch_angle(pitch_angle),
		.yaw_rate(yaw_rate),
		.kp(kp),
		.sample(sample),
		.motors(motors.src)
	);

	motor_pwm motor_pwm0 (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.tick(tick),
		.motors(motors.dst),
		.motor_1_pwm(motor_1_pwm),
		.motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm),
		.motor_4_pwm(motor_4_pwm)
	);

endmodule

`default_nettype wire

// ==== dv/flight_core_tb.sv ====
// Directed testbench of the flight core with APB, receiver pulses, motor rate and ESC checks
`timescale 1ns/1ps
`default_nettype none

module flight_core_tb;

	localparam int CLK_NS    = 4;
	localparam int TICK_CYC  = flight_pkg::TICK_DIV;
	localparam int FRAME_CYC = flight_pkg::PWM_FRAME_US * TICK_CYC;
	// All receiver pulses driven over the run in microseconds
	localparam int PULSE_US_TOTAL = 1000 + 1500 + 2000 + 2200 + 1500 + 1600 + 1400 + 1540
		+ 1020 + 1500;
	// One idle frame plus up to three frames in the ESC test
	localparam int FRAME_US_TOTAL = 4 * flight_pkg::PWM_FRAME_US;
	localparam longint WATCHDOG_NS = 2 * (PULSE_US_TOTAL + FRAME_US_TOTAL) * TICK_CYC * CLK_NS;

	logic                        sys_clk;
	logic                        resetn;
	logic [regs_pkg::ADDR_W-1:0] paddr;
	logic                        psel;
	logic                        penable;
	logic                        pwrite;
	logic [regs_pkg::DATA_W-1:0] pwdata;
	wire  [regs_pkg::DATA_W-1:0] prdata;
	wire                         pready;
	wire                         pslverr;
	// Throttle, roll, pitch, yaw from bit 0 up
	logic [3:0]                  rc_pwm;
	wire  [3:0]                  esc_pwm;

	logic [31:0] lcg_state;
	string       cur_test;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;
	// Stick values implied by the last pulse on each channel
	int          stick_val [4];

	flight_core dut0 (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.throttle_pwm(rc_pwm[0]),
		.roll_pwm(rc_pwm[1]),
		.pitch_pwm(rc_pwm[2]),
		.yaw_pwm(rc_pwm[3]),
		.motor_1_pwm(esc_pwm[0]),
		.motor_2_pwm(esc_pwm[1]),
		.motor_3_pwm(esc_pwm[2]),
		.motor_4_pwm(esc_pwm[3])
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_NS / 2) sys_clk = ~sys_clk;
	end

	// Run limit is twice the total pulse and frame time
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the run did not finish in time");
		$display("Something failed");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] rand_imu();
		logic [31:0] r;
		r = lcg_next();
		return {8'h00, r[31:8]};
	endfunction

	// Receiver rule (width - 1000) / 4 held to 0..250
	function automatic int stick_of_width(input int us);
		int v;
		v = (us - flight_pkg::PULSE_MIN_US) / 4;
		if (v < 0)
			v = 0;
		if (v > flight_pkg::STICK_MAX)
			v = flight_pkg::STICK_MAX;
		return v;
	endfunction

	task automatic note_mismatch(input logic [31:0] exp, input logic [31:0] act);
		$display("[ERROR] %s: expected %h, actual %h", cur_test, exp, act);
		errors++;
		test_errors++;
	endtask

	task automatic note_problem(input string what);
		$display("[ERROR] %s: %s", cur_test, what);
		errors++;
		test_errors++;
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: pass", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, test_errors);
		end
	endtask

	// Starts on a falling edge and returns on the one after the access phase
	task automatic apb_write(input logic [regs_pkg::ADDR_W-1:0] addr, input logic [31:0] data,
		output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge sys_clk);
		penable = 1'b1;
		#1;
		err = pslverr;
		if (!pready)
			note_problem("pready low in a write access phase");
		@(negedge sys_clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input logic [regs_pkg::ADDR_W-1:0] addr, output logic [31:0] data,
		output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge sys_clk);
		penable = 1'b1;
		#1;
		data = prdata;
		err  = pslverr;
		if (!pready)
			note_problem("pready low in a read access phase");
		@(negedge sys_clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// One receiver pulse and time for sync and capture
	task automatic drive_pulse(input int ch, input int width_us);
		rc_pwm[ch] = 1'b1;
		repeat (width_us * TICK_CYC) @(negedge sys_clk);
		rc_pwm[ch] = 1'b0;
		repeat (3 * TICK_CYC) @(negedge sys_clk);
		stick_val[ch] = stick_of_width(width_us);
	endtask

	// Reference model of the P correction and quad-X mix
	task automatic expect_motors(input int kp, input logic [31:0] imu, output logic [31:0] word,
		output logic hi, output logic lo);
		int ang [3];
		int corr [3];
		int m [4];
		ang[0] = int'($signed(imu[7:0]));
		ang[1] = int'($signed(imu[15:8]));
		ang[2] = int'($signed(imu[23:16]));
		// Roll, pitch, yaw sticks sit on channels 1 to 3
		for (int i = 0; i < 3; i++)
			corr[i] = ((stick_val[i+1] - flight_pkg::STICK_MID - ang[i]) * kp)
				>>> flight_pkg::KP_SHIFT;
		m[0] = stick_val[0] + corr[1] + corr[0] - corr[2];
		m[1] = stick_val[0] + corr[1] - corr[0] + corr[2];
		m[2] = stick_val[0] - corr[1] - corr[0] - corr[2];
		m[3] = stick_val[0] - corr[1] + corr[0] + corr[2];
		hi = 1'b0;
		lo = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (m[i] > flight_pkg::STICK_MAX) begin
				m[i] = flight_pkg::STICK_MAX;
				hi   = 1'b1;
			end
			if (m[i] < 0) begin
				m[i] = 0;
				lo   = 1'b1;
			end
			if (stick_val[0] < flight_pkg::ARM_MIN)
				m[i] = 0;
			word[8*i +: 8] = 8'(m[i]);
		end
	endtask

	task automatic reset_and_regs();
		logic [31:0] rd;
		logic        err;
		start_test("reset_and_regs");
		apb_read(regs_pkg::REG_MOTOR, rd, err);
		if (rd != 32'h0)
			note_mismatch(32'h0, rd);
		// No update yet, so the ESC lines stay quiet for a whole frame
		for (int i = 0; i < FRAME_CYC + TICK_CYC; i++) begin
			@(negedge sys_clk);
			if (esc_pwm != 4'h0) begin
				note_problem("ESC output went high before any motor update");
				break;
			end
		end
		apb_write(regs_pkg::REG_CTRL, 32'h0000_005a, err);
		if (err)
			note_problem("pslverr on a write to REG_CTRL");
		apb_read(regs_pkg::REG_CTRL, rd, err);
		if (rd != 32'h0000_005a)
			note_mismatch(32'h0000_005a, rd);
		apb_read(5'h10, rd, err);
		if (!err)
			note_problem("no pslverr on a read of unmapped offset 0x10");
		apb_write(regs_pkg::REG_STICK, 32'h1234_5678, err);
		if (!err)
			note_problem("no pslverr on a write to read-only REG_STICK");
		finish_test();
	endtask

	task automatic receiver_capture();
		logic [31:0] rd;
		logic [31:0] exp;
		logic        err;
		start_test("receiver_capture");
		drive_pulse(0, 1000);
		drive_pulse(1, 1500);
		drive_pulse(2, 2000);
		drive_pulse(3, 2200);
		for (int i = 0; i < 4; i++)
			exp[8*i +: 8] = 8'(stick_val[i]);
		apb_read(regs_pkg::REG_STICK, rd, err);
		if (rd != exp)
			note_mismatch(exp, rd);
		finish_test();
	endtask

	task automatic mixer_arithmetic();
		logic [31:0] rd;
		logic [31:0] exp;
		logic [31:0] imu;
		logic [7:0]  kp;
		logic        err;
		logic        hi;
		logic        lo;
		logic        saw_hi;
		logic        saw_lo;
		start_test("mixer_arithmetic");
		drive_pulse(0, 1500);
		drive_pulse(1, 1600);
		drive_pulse(2, 1400);
		drive_pulse(3, 1540);
		saw_hi = 1'b0;
		saw_lo = 1'b0;
		for (int n = 0; n < 16; n++) begin
			kp  = 8'(lcg_next() >> 24);
			imu = rand_imu();
			apb_write(regs_pkg::REG_CTRL, {24'h0, kp}, err);
			apb_write(regs_pkg::REG_IMU, imu, err);
			// Read access lands two cycles after the write access
			apb_read(regs_pkg::REG_MOTOR, rd, err);
			expect_motors(int'(kp), imu, exp, hi, lo);
			saw_hi = saw_hi | hi;
			saw_lo = saw_lo | lo;
			if (rd != exp)
				note_mismatch(exp, rd);
		end
		if (!saw_hi || !saw_lo)
			note_problem("random samples never reached both motor clamp limits");
		finish_test();
	endtask

	task automatic disarm();
		logic [31:0] rd;
		logic        err;
		start_test("disarm");
		// Stick 5 is under the arming threshold
		drive_pulse(0, 1020);
		apb_write(regs_pkg::REG_CTRL, 32'h0000_00ff, err);
		for (int n = 0; n < 4; n++) begin
			apb_write(regs_pkg::REG_IMU, rand_imu(), err);
			apb_read(regs_pkg::REG_MOTOR, rd, err);
			if (rd != 32'h0)
				note_mismatch(32'h0, rd);
		end
		finish_test();
	endtask

	task automatic back_to_back();
		logic [31:0] rd;
		logic [31:0] exp;
		logic [31:0] imu_a;
		logic [31:0] imu_b;
		logic        err;
		logic        hi;
		logic        lo;
		start_test("back_to_back");
		drive_pulse(0, 1500);
		imu_a = rand_imu();
		imu_b = rand_imu();
		apb_write(regs_pkg::REG_CTRL, 32'h0000_0018, err);
		apb_write(regs_pkg::REG_IMU, imu_a, err);
		apb_write(regs_pkg::REG_IMU, imu_b, err);
		apb_read(regs_pkg::REG_MOTOR, rd, err);
		expect_motors(24, imu_b, exp, hi, lo);
		if (rd != exp)
			note_mismatch(exp, rd);
		finish_test();
	endtask

	task automatic esc_pulses();
		logic [31:0] rd;
		logic [31:0] exp;
		logic        err;
		logic        hi;
		logic        lo;
		logic        prev;
		logic        found;
		int          high_cyc [4];
		int          want;
		start_test("esc_pulses");
		apb_write(regs_pkg::REG_CTRL, 32'h0000_0008, err);
		apb_write(regs_pkg::REG_IMU, 32'h0, err);
		apb_read(regs_pkg::REG_MOTOR, rd, err);
		expect_motors(8, 32'h0, exp, hi, lo);
		if (rd != exp)
			note_mismatch(exp, rd);
		// Skip any frame start that could still carry the old rates
		repeat (2 * TICK_CYC) @(negedge sys_clk);
		prev  = esc_pwm[0];
		found = 1'b0;
		for (int i = 0; i < 2 * FRAME_CYC; i++) begin
			@(negedge sys_clk);
			if (!prev && esc_pwm[0]) begin
				found = 1'b1;
				break;
			end
			prev = esc_pwm[0];
		end
		if (!found) begin
			note_problem("no ESC pulse started within two frames");
		end else begin
			for (int ch = 0; ch < 4; ch++)
				high_cyc[ch] = 0;
			for (int i = 0; i < FRAME_CYC; i++) begin
				for (int ch = 0; ch < 4; ch++)
					high_cyc[ch] += int'(esc_pwm[ch]);
				@(negedge sys_clk);
			end
			for (int ch = 0; ch < 4; ch++) begin
				want = (flight_pkg::PULSE_MIN_US + 4 * int'(exp[8*ch +: 8])) * TICK_CYC;
				if (high_cyc[ch] > want + TICK_CYC || high_cyc[ch] < want - TICK_CYC)
					note_mismatch(want, high_cyc[ch]);
			end
		end
		finish_test();
	endtask

	initial begin
		resetn       = 1'b0;
		paddr        = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = '0;
		rc_pwm       = 4'h0;
		lcg_state    = 32'h73156b92;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		for (int i = 0; i < 4; i++)
			stick_val[i] = 0;
		repeat (4) @(negedge sys_clk);
		resetn = 1'b1;
		@(negedge sys_clk);

		reset_and_regs();
		receiver_capture();
		mixer_arithmetic();
		disarm();
		back_to_back();
		esc_pulses();

		$display("tests run %0d, tests with errors %0d, total errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/flight_pkg.sv
logic/regs_pkg.sv
logic/flight_if.sv
logic/rc_capture.sv
logic/apb_regs.sv
logic/control_mixer.sv
logic/motor_pwm.sv
logic/flight_core.sv
dv/flight_core_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := flight_core_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
